// ==== logic/vlane_mulshift_cfg.svh ====
// width settings for the lane multiply/shift unit, included by the package and any RTL that sizes on them.
`ifndef VLANE_MULSHIFT_CFG_SVH
`define VLANE_MULSHIFT_CFG_SVH

// data word width of one lane.
// the half-word ops split this in two, so keep it even.
`define VLANE_WIDTH 32

// shift amount width.
// must be log2 of the word width.
// the right-shift amount relies on width wrapping to zero here.
`define VLANE_LOG2WIDTH 5

// half-word width of the lower/upper multiplies.
`define VLANE_HALF_WIDTH (`VLANE_WIDTH / 2)

// full product width kept after the multiplier.
// the two extra sign bits of the 33 x 33 product are dropped.
`define VLANE_PROD_WIDTH (2 * `VLANE_WIDTH)

`endif

// ==== logic/vlane_mulshift_pkg.sv ====
// shared types of the lane multiply/shift unit, referenced by scoped name from every stage.
`include "vlane_mulshift_cfg.svh"

package vlane_mulshift_pkg;

  // one lane data word.
  typedef logic [`VLANE_WIDTH-1:0] word_t;

  // word plus one extension bit for the signed multiplier.
  typedef logic [`VLANE_WIDTH:0] mul_operand_t;

  // shift amount.
  typedef logic [`VLANE_LOG2WIDTH-1:0] shamt_t;

  // opcode map.
  // bit 4 half-word, bit 3 saturate, bit 2 multiply.
  // bit 1 set picks the signed flavour, bit 0 upper half or right.
  typedef enum logic [4:0] {
    op_shl      = 5'd0,
    op_shrl     = 5'd1,
    op_zero     = 5'd2,
    op_shra     = 5'd3,
    op_mullou   = 5'd4,
    op_mulhiu   = 5'd5,
    op_mullo    = 5'd6,
    op_mulhi    = 5'd7,
    op_shl_satu = 5'd8,
    op_shl_sat  = 5'd10,
    op_lmulu    = 5'd20,
    op_umulu    = 5'd21,
    op_lmul     = 5'd22,
    op_umul     = 5'd23
  } mulshift_op_e;

  // multiplier inputs already extended to 33 bits.
  typedef struct packed {
    mul_operand_t dataa;
    mul_operand_t datab;
  } mul_operands_t;

  // output-side controls worked out alongside the operands.
  typedef struct packed {
    logic  zero_out;
    logic  saturate;
    logic  sel_hi;
    word_t sat_value;
  } result_ctrl_t;

endpackage

// ==== logic/mulshift_operand_prep.sv ====
// input side of the lane multiply/shift unit; combinational decode feeding the multiplier and selector.
`timescale 1ns/100ps
`include "vlane_mulshift_cfg.svh"

module mulshift_operand_prep (
  input  vlane_mulshift_pkg::mulshift_op_e  op,
  input  vlane_mulshift_pkg::word_t         op_a,
  input  vlane_mulshift_pkg::word_t         op_b,
  input  vlane_mulshift_pkg::shamt_t        sa,
  output vlane_mulshift_pkg::mul_operands_t operands,
  output vlane_mulshift_pkg::result_ctrl_t  ctrl
);

  // opcode fields.
  logic is_half;
  logic is_sat;
  logic is_mul;
  logic is_signed;
  logic dir;

  // half-word picks before extension.
  logic [`VLANE_HALF_WIDTH-1:0] half_a;
  logic [`VLANE_HALF_WIDTH-1:0] half_b;

  // operands after the half-word step.
  vlane_mulshift_pkg::word_t opa_sel;
  vlane_mulshift_pkg::word_t opb_mul;

  // left-shift amount for both directions.
  vlane_mulshift_pkg::shamt_t left_sa;

  // power of two that stands in for operand b on shifts.
  vlane_mulshift_pkg::mul_operand_t decoded_sa;

  // signed saturation extreme.
  vlane_mulshift_pkg::word_t signed_sat;

  assign is_half   = op[4];
  assign is_sat    = op[3];
  assign is_mul    = op[2];
  assign is_signed = op[1];
  assign dir       = op[0];

  // upper halves when bit 0 is set, lower otherwise.
  assign half_a = dir ? op_a[`VLANE_WIDTH-1:`VLANE_HALF_WIDTH]
                      : op_a[`VLANE_HALF_WIDTH-1:0];
  assign half_b = dir ? op_b[`VLANE_WIDTH-1:`VLANE_HALF_WIDTH]
                      : op_b[`VLANE_HALF_WIDTH-1:0];

  // half ops are always multiplies.
  // extend by sign only for the signed variants.
  always_comb
  begin
    if (is_half)
    begin
      opa_sel = {{`VLANE_HALF_WIDTH{is_signed & half_a[`VLANE_HALF_WIDTH-1]}}, half_a};
      opb_mul = {{`VLANE_HALF_WIDTH{is_signed & half_b[`VLANE_HALF_WIDTH-1]}}, half_b};
    end
    else
    begin
      opa_sel = op_a;
      opb_mul = op_b;
    end
  end

  // right shift is a left shift by width minus sa, keeping the high word.
  // width itself wraps to zero, so sa of zero lands on 2^0.
  // that gives op_a back in the low word, picked by sel_hi below.
  assign left_sa = dir ? (vlane_mulshift_pkg::shamt_t'(`VLANE_WIDTH) - sa) : sa;

  // one-hot decode.
  // bit 32 never sets, so the extended operand stays positive.
  always_comb
  begin
    decoded_sa = '0;
    for (int i = 0; i < `VLANE_WIDTH; i++)
    begin
      if (left_sa == vlane_mulshift_pkg::shamt_t'(i))
      begin
        decoded_sa[i] = 1'b1;
      end
    end
  end

  // operand a carries its sign for signed multiplies and arithmetic shifts.
  assign operands.dataa = {is_signed & opa_sel[`VLANE_WIDTH-1], opa_sel};

  // operand b is the real operand or the shift factor.
  assign operands.datab = is_mul ? {is_signed & opb_mul[`VLANE_WIDTH-1], opb_mul}
                                 : decoded_sa;

  // max positive for a non-negative a, min negative otherwise.
  assign signed_sat = opa_sel[`VLANE_WIDTH-1] ? {1'b1, {(`VLANE_WIDTH-1){1'b0}}}
                                              : {1'b0, {(`VLANE_WIDTH-1){1'b1}}};

  // the zero opcode sits in the unused signed left-shift slot.
  assign ctrl.zero_out = (op == vlane_mulshift_pkg::op_zero);

  assign ctrl.saturate = is_sat;

  // high word for upper multiplies and nonzero right shifts.
  assign ctrl.sel_hi = (is_mul & dir) | (~is_mul & dir & (|sa));

  // unsigned saturation clamps to all ones.
  assign ctrl.sat_value = is_signed ? signed_sat : {`VLANE_WIDTH{1'b1}};

endmodule

// ==== logic/mulshift_multiplier.sv ====
// processing part of the lane multiply/shift unit; one registered signed 33 x 33 multiply.
`timescale 1ns/100ps
`include "vlane_mulshift_cfg.svh"

module mulshift_multiplier (
  input  logic                              clk,
  input  logic                              resetn,
  input  logic                              en,
  input  vlane_mulshift_pkg::mul_operands_t operands,
  output vlane_mulshift_pkg::word_t         prod_hi,
  output vlane_mulshift_pkg::word_t         prod_lo
);

  // operands sign-extended to the kept product width.
  logic signed [`VLANE_PROD_WIDTH-1:0] a_wide;
  logic signed [`VLANE_PROD_WIDTH-1:0] b_wide;

  // low 64 bits of the full 66-bit product.
  logic signed [`VLANE_PROD_WIDTH-1:0] product;

  // widen from 33 bits by repeating the extension bit.
  assign a_wide = {{(`VLANE_WIDTH-1){operands.dataa[`VLANE_WIDTH]}}, operands.dataa};
  assign b_wide = {{(`VLANE_WIDTH-1){operands.datab[`VLANE_WIDTH]}}, operands.datab};

  // low bits of a product do not depend on the bits above them.
  // the 64-bit multiply matches the low 64 bits of the 66-bit one,
  // which drops the top two bits.
  assign product = a_wide * b_wide;

  // single pipe stage.
  // holds while en is low.
  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      prod_hi <= '0;
      prod_lo <= '0;
    end
    else if (en)
    begin
      prod_hi <= product[`VLANE_PROD_WIDTH-1:`VLANE_WIDTH];
      prod_lo <= product[`VLANE_WIDTH-1:0];
    end
  end

endmodule

// ==== logic/mulshift_result_select.sv ====
// output side of the lane multiply/shift unit; registers controls and picks the result word.
`timescale 1ns/100ps

module mulshift_result_select (
  input  logic                             clk,
  input  logic                             resetn,
  input  logic                             en,
  input  vlane_mulshift_pkg::result_ctrl_t ctrl,
  input  vlane_mulshift_pkg::word_t        prod_hi,
  input  vlane_mulshift_pkg::word_t        prod_lo,
  output vlane_mulshift_pkg::word_t        result
);

  // controls delayed to match the product register.
  vlane_mulshift_pkg::result_ctrl_t ctrl_q;

  // high word nonzero means the shift overflowed.
  logic overflow;

  // control bits.
  // reset forces a zero result until the first enabled edge.
  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      ctrl_q.zero_out <= 1'b1;
      ctrl_q.saturate <= 1'b0;
      ctrl_q.sel_hi   <= 1'b0;
    end
    else if (en)
    begin
      ctrl_q.zero_out <= ctrl.zero_out;
      ctrl_q.saturate <= ctrl.saturate;
      ctrl_q.sel_hi   <= ctrl.sel_hi;
    end
  end

  // clamp value of the saturating shifts.
  always_ff @(posedge clk)
  begin
    if (en)
    begin
      ctrl_q.sat_value <= ctrl.sat_value;
    end
  end

  assign overflow = |prod_hi;

  // zero first, then saturation, then the chosen half.
  always_comb
  begin
    if (ctrl_q.zero_out)
    begin
      result = '0;
    end
    else if (ctrl_q.saturate && overflow)
    begin
      result = ctrl_q.sat_value;
    end
    else if (ctrl_q.sel_hi)
    begin
      result = prod_hi;
    end
    else
    begin
      result = prod_lo;
    end
  end

endmodule

// ==== logic/vlane_mulshift.sv ====
// top of the lane multiply/shift unit; one enabled edge from operands to result.
`timescale 1ns/100ps

module vlane_mulshift (
  input  logic                             clk,
  input  logic                             resetn,
  input  logic                             en,
  input  vlane_mulshift_pkg::word_t        op_a,
  input  vlane_mulshift_pkg::word_t        op_b,
  input  vlane_mulshift_pkg::shamt_t       sa,
  input  vlane_mulshift_pkg::mulshift_op_e op,
  output vlane_mulshift_pkg::word_t        result
);

  // input side to multiplier.
  vlane_mulshift_pkg::mul_operands_t operands;

  // input side to selector.
  vlane_mulshift_pkg::result_ctrl_t ctrl;

  // registered product halves.
  vlane_mulshift_pkg::word_t prod_hi;
  vlane_mulshift_pkg::word_t prod_lo;

  // decode and operand shaping.
  // same cycle as issue.
  mulshift_operand_prep prep_i (
    .op       (op),
    .op_a     (op_a),
    .op_b     (op_b),
    .sa       (sa),
    .operands (operands),
    .ctrl     (ctrl)
  );

  // product register stage.
  mulshift_multiplier mult_i (
    .clk      (clk),
    .resetn   (resetn),
    .en       (en),
    .operands (operands),
    .prod_hi  (prod_hi),
    .prod_lo  (prod_lo)
  );

  // control register stage and final mux.
  mulshift_result_select sel_i (
    .clk     (clk),
    .resetn  (resetn),
    .en      (en),
    .ctrl    (ctrl),
    .prod_hi (prod_hi),
    .prod_lo (prod_lo),
    .result  (result)
  );

endmodule

// ==== verif/tb_clock_gen.sv ====
// free-running testbench clock for the lane multiply/shift unit, instantiated by the testbench top.
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk
);

  // half of the 40 ns period.
  localparam int half_period = 20;

  initial
  begin
    clk = 1'b0;
  end

  always #half_period clk = ~clk;

endmodule

// ==== verif/vlane_mulshift_chk.sv ====
// assertion checker bound onto the lane multiply/shift top level from the testbench.
`timescale 1ns/100ps

module vlane_mulshift_chk (
  input logic                             clk,
  input logic                             resetn,
  input logic                             en,
  input vlane_mulshift_pkg::mulshift_op_e op,
  input vlane_mulshift_pkg::word_t        result
);

  // a reset edge leaves the output at zero.
  property reset_clears_result;
    @(posedge clk) !resetn |=> (result == '0);
  endproperty

  // registers hold on idle edges, so the output does too.
  property idle_holds_result;
    @(posedge clk) (resetn && !en) |=> $stable(result);
  endproperty

  // zero opcode issued.
  // output reads zero one edge later.
  property zero_op_clears_result;
    @(posedge clk) (resetn && en && (op == vlane_mulshift_pkg::op_zero)) |=> (result == '0);
  endproperty

  reset_zero_a: assert property (reset_clears_result)
    else $error("result not zero in the cycle after reset");

  idle_hold_a: assert property (idle_holds_result)
    else $error("result changed across an edge with en low");

  zero_op_a: assert property (zero_op_clears_result)
    else $error("zero opcode did not give a zero result");

endmodule

// ==== verif/tb_vlane_mulshift.sv ====
// testbench top for the lane multiply/shift unit; replays the golden vectors and checks each result.
`timescale 1ns/100ps

module tb_vlane_mulshift;

  // golden file layout.
  localparam int vector_count = 30;
  localparam int field_count  = 5;
  localparam int reset_cycles = 16;

  // worst case is five edges per vector, plus reset and slack.
  localparam int unsigned cycle_limit = 16 + 5 * vector_count + 64;

  logic                             clk;
  logic                             resetn;
  logic                             en;
  vlane_mulshift_pkg::word_t        op_a;
  vlane_mulshift_pkg::word_t        op_b;
  vlane_mulshift_pkg::shamt_t       sa;
  vlane_mulshift_pkg::mulshift_op_e op;
  vlane_mulshift_pkg::word_t        result;

  // op, op_a, op_b, sa and expected result per vector.
  logic [31:0] golden_mem [0:vector_count*field_count-1];

  int unsigned cycle_count = 0;

  tb_clock_gen clk_gen_i (
    .clk (clk)
  );

  vlane_mulshift dut_i (
    .clk    (clk),
    .resetn (resetn),
    .en     (en),
    .op_a   (op_a),
    .op_b   (op_b),
    .sa     (sa),
    .op     (op),
    .result (result)
  );

  bind vlane_mulshift vlane_mulshift_chk chk_i (
    .clk    (clk),
    .resetn (resetn),
    .en     (en),
    .op     (op),
    .result (result)
  );

  // compare one value, stop at the first mismatch.
  task automatic check_value(input string name, input vlane_mulshift_pkg::word_t actual,
                             input vlane_mulshift_pkg::word_t expected);
    if (actual !== expected)
    begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, actual, expected);
      $display("Checks failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // put one golden vector on the inputs with en high.
  task automatic drive_vector(input int idx);
    int base;
    base = idx * field_count;
    en   <= 1'b1;
    op   <= vlane_mulshift_pkg::mulshift_op_e'(golden_mem[base][4:0]);
    op_a <= golden_mem[base + 1];
    op_b <= golden_mem[base + 2];
    sa   <= vlane_mulshift_pkg::shamt_t'(golden_mem[base + 3]);
  endtask

  // run length guard.
  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
      $display("run exceeded %0d cycles before all vectors were checked", cycle_limit);
      $display("Checks failed");
      $fatal(1, "cycle limit reached");
    end
  end

  initial
  begin
    int gap;
    bit next_issued;
    resetn = 1'b0;
    en     = 1'b0;
    op_a   = '0;
    op_b   = '0;
    sa     = '0;
    op     = vlane_mulshift_pkg::op_zero;
    void'($urandom(32'hafd5));
    $readmemh("verif/vlane_mulshift_golden.txt", golden_mem);

    // reset, then the output must read zero.
    repeat (reset_cycles - 1) @(posedge clk);
    @(negedge clk);
    check_value("result", result, '0);
    @(posedge clk);
    resetn <= 1'b1;
    drive_vector(0);

    for (int i = 0; i < vector_count; i++)
    begin
      // vector i is captured on this edge.
      @(posedge clk);
      gap = $urandom % 4;
      next_issued = (gap == 0) && (i + 1 < vector_count);
      if (next_issued)
      begin
        drive_vector(i + 1);
      end
      else
      begin
        en <= 1'b0;
      end
      @(negedge clk);
      check_value("result", result, golden_mem[i * field_count + 4]);
      if (!next_issued)
      begin
        // result must hold through the idle gap.
        repeat (gap)
        begin
          @(posedge clk);
          @(negedge clk);
          check_value("result", result, golden_mem[i * field_count + 4]);
        end
        if (i + 1 < vector_count)
        begin
          @(posedge clk);
          drive_vector(i + 1);
        end
      end
    end

    // second reset clears the last result.
    @(posedge clk);
    resetn <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_value("result", result, '0);

    $display("All checks passed");
    $finish;
  end

endmodule

// ==== vlane_mulshift.f ====
+incdir+logic
logic/vlane_mulshift_pkg.sv
logic/mulshift_operand_prep.sv
logic/mulshift_multiplier.sv
logic/mulshift_result_select.sv
logic/vlane_mulshift.sv
verif/tb_clock_gen.sv
verif/vlane_mulshift_chk.sv
verif/tb_vlane_mulshift.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the lane multiply/shift testbench with Verilator and runs it from the project root.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_vlane_mulshift \
  -f vlane_mulshift.f \
  -o tb_vlane_mulshift

# the exit status of the simulation is the result of the run.
./obj_dir/tb_vlane_mulshift

// ==== verif/vlane_mulshift_golden.txt ====
// one operation per line, hex words in this order.
// opcode, operand a, operand b, shift amount, expected result.
// full-word multiplies.
04 00000003 00000005 00 0000000f
05 ffffffff ffffffff 00 fffffffe
04 ffffffff ffffffff 00 00000001
07 80000000 80000000 00 40000000
06 fffffffe fffffffd 00 00000006
07 fffffffe 00000003 00 ffffffff
05 80000000 00000004 00 00000002
06 12345678 00000010 00 23456780
// half-word multiplies.
14 0000ffff 0000ffff 00 fffe0001
16 0000ffff 00000002 00 fffffffe
16 1234fffe abcd0003 00 fffffffa
14 1234fffe abcd0003 00 0002fffa
17 fffe0000 00050000 00 ffffffff
15 fffe0000 00050000 00 00000000
// shifts. operand b plays no part.
00 00000001 0000ffff 1f 80000000
00 12345678 0000ffff 04 23456780
00 deadbeef 0000ffff 00 deadbeef
01 80000000 0000ffff 1f 00000001
01 deadbeef 0000ffff 04 0deadbee
01 deadbeef 0000ffff 00 deadbeef
03 80000000 0000ffff 1f ffffffff
03 deadbeef 0000ffff 04 fdeadbee
03 deadbeef 0000ffff 00 deadbeef
03 40000000 0000ffff 1e 00000001
// zero opcode.
02 deadbeef 12345678 05 00000000
// saturating left shifts.
08 80000000 00000000 01 ffffffff
08 00001234 00000000 04 00012340
0a 40000000 00000000 02 7fffffff
0a c0000000 00000000 02 80000000
0a 00000123 00000000 04 00001230
